//--- verification/z80_testdata.txt
# M addr b0..b7 = eight bytes preloaded from addr; W addr byte = next expected write
# H addr = address the core keeps fetching after HALT
M 0000 3E 5A 32 00 80 01 01 80
M 0008 3E 11 02 11 02 80 06 33
M 0010 78 12 01 00 90 0A 32 03
M 0018 80 3A 01 90 32 04 80 21
M 0020 05 80 36 A5 34 35 3E FF
M 0028 3C 32 06 80 0E 01 28 05
M 0030 3E EE 32 07 80 3E 77 32
M 0038 07 80 0E 01 20 05 3E 88
M 0040 32 08 80 21 00 98 01 00
M 0048 79 09 7C 32 09 80 7D 32
M 0050 0A 80 0E 01 38 05 3E EE
M 0058 32 0B 80 3E 99 32 0B 80
M 0060 0E 01 30 05 3E 44 32 0C
M 0068 80 23 1B 7D 32 0D 80 7A
M 0070 32 0E 80 7B 32 0F 80 3E
M 0078 3C 08 32 10 80 08 32 11
M 0080 80 06 03 16 00 14 7A 32
M 0088 12 80 0E 01 10 F7 3E FE
M 0090 32 13 80 3D 32 14 80 21
M 0098 02 90 46 78 32 15 80 0E
M 00A0 01 18 02 0E 55 0C 71 76
M 9000 C3 7E 4B 00 00 00 00 00
# Plain loads and stores
W 8000 5A
W 8001 11
W 8002 33
W 8003 C3
W 8004 7E
# LD (HL),n then INC (HL) and DEC (HL)
W 8005 A5
W 8005 A6
W 8005 A5
# INC A from FF, then JR Z taken and JR NZ not taken
W 8006 00
W 8007 77
W 8008 88
# ADD HL,BC carry out, JR C taken, JR NC not taken
W 8009 11
W 800A 00
W 800B 99
W 800C 44
# INC HL and DEC DE
W 800D 01
W 800E 80
W 800F 01
# EX AF,AF' round trip
W 8010 00
W 8011 3C
# DJNZ with B = 3
W 8012 01
W 8012 02
W 8012 03
W 8013 FE
W 8014 FD
W 8015 4B
W 9002 02
H 00A7

//--- compile.f
source/z80_pkg.sv
source/z80_regfile.sv
source/z80_alu.sv
source/z80_bus_master.sv
source/z80_control.sv
source/z80_core.sv
verification/tb_wb_memory.sv
verification/tb_z80_core.sv

//--- Bender.yml
package:
  name: z80_core

sources:
  - source/z80_pkg.sv
  - source/z80_regfile.sv
  - source/z80_alu.sv
  - source/z80_bus_master.sv
  - source/z80_control.sv
  - source/z80_core.sv
  - target: simulation
    files:
      - verification/tb_wb_memory.sv
      - verification/tb_z80_core.sv

//--- verification/tb_z80_core.sv
`timescale 1ns/1ps

module tb_z80_core;
    import z80_pkg::*;

    localparam string DATA_FILE         = "verification/z80_testdata.txt";
    localparam int    CYCLES_PER_RECORD = 200;
    localparam int    HALT_QUIET        = 50;

    logic    clk_z80 = 1'b0;
    logic    i_rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    acc;
    logic    acc_we;
    addr_t   acc_adr;
    data_t   acc_dat;
    int      proto_errs;

    addr_t exp_adr [$];
    data_t exp_dat [$];
    addr_t halt_adr   = '0;
    int    m_records  = 0;
    logic  loaded     = 1'b0;
    logic  first_seen = 1'b0;
    int    halt_hits  = 0;
    int    data_errs  = 0;
    int    flow_errs  = 0;

    always #2 clk_z80 = ~clk_z80;

    z80_core u_z80_core (
        .clk_z80(clk_z80),
        .i_rst  (i_rst),
        .o_wb   (wb_req),
        .i_wb   (wb_rsp)
    );

    tb_wb_memory u_tb_wb_memory (
        .clk_z80     (clk_z80),
        .i_rst       (i_rst),
        .i_req       (wb_req),
        .o_rsp       (wb_rsp),
        .o_acc       (acc),
        .o_acc_we    (acc_we),
        .o_acc_adr   (acc_adr),
        .o_acc_dat   (acc_dat),
        .o_proto_errs(proto_errs)
    );

    task automatic read_testdata();
        int                 fd;
        int                 n;
        int                 i;
        logic [7:0]         kind;
        addr_t              adr;
        data_t              dat;
        logic [8*120-1:0]   line;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test data file %s", DATA_FILE);
            flow_errs++;
            return;
        end
        n = $fscanf(fd, " %c", kind);
        while (n == 1) begin
            case (kind)
                "#": n = $fgets(line, fd);
                "M": begin
                    n = $fscanf(fd, "%h", adr);
                    for (i = 0; i < 8; i++) begin
                        n = $fscanf(fd, "%h", dat);
                        u_tb_wb_memory.load_byte(adr + i, dat);
                    end
                    m_records++;
                end
                "W": begin
                    n = $fscanf(fd, "%h %h", adr, dat);
                    exp_adr.push_back(adr);
                    exp_dat.push_back(dat);
                end
                "H": begin
                    n = $fscanf(fd, "%h", adr);
                    halt_adr = adr;
                end
                default: begin
                    $display("Unknown record type '%c' in the test data file", kind);
                    flow_errs++;
                    n = $fgets(line, fd);
                end
            endcase
            n = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
    endtask

    task automatic check_write(input addr_t adr, input data_t dat);
        addr_t ea;
        data_t ed;
        if (halt_hits > 0) begin
            $display("Write of %02h to %04h after the core reached HALT", dat, adr);
            flow_errs++;
        end
        if (exp_adr.size() == 0) begin
            $display("Write of %02h to %04h came after all expected writes", dat, adr);
            flow_errs++;
        end else begin
            ea = exp_adr.pop_front();
            ed = exp_dat.pop_front();
            if (adr != ea) begin
                $display("Error %0t ns: adr expected %04h, got %04h", $time, ea, adr);
                data_errs++;
            end
            if (dat != ed) begin
                $display("Error %0t ns: dat expected %02h, got %02h", $time, ed, dat);
                data_errs++;
            end
        end
    endtask

    task automatic print_counts();
        $display("Errors: data %0d, sequence %0d, protocol %0d",
                 data_errs, flow_errs, proto_errs);
    endtask

    // The access pulse spans the rising edge
    always @(posedge clk_z80) begin
        if (acc) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                if (acc_we) begin
                    $display("First bus access was a write to %04h instead of a fetch",
                             acc_adr);
                    flow_errs++;
                end else if (acc_adr != 16'h0000) begin
                    $display("Error %0t ns: adr expected 0000, got %04h", $time, acc_adr);
                    data_errs++;
                end
            end
            if (acc_we) begin
                check_write(acc_adr, acc_dat);
            end else if (acc_adr == halt_adr) begin
                halt_hits++;
            end else if (exp_adr.size() == 0) begin
                $display("Error %0t ns: adr expected %04h, got %04h",
                         $time, halt_adr, acc_adr);
                data_errs++;
            end
        end
    end

    initial begin
        i_rst = 1'b1;
        u_tb_wb_memory.fill_memory();
        read_testdata();
        loaded = 1'b1;
        repeat (4) begin
            @(negedge clk_z80);
            if (wb_req.cyc || wb_req.stb) begin
                $display("cyc or stb went high while reset was asserted");
                flow_errs++;
            end
        end
        i_rst = 1'b0;
        wait (halt_hits >= 3);
        repeat (HALT_QUIET) @(posedge clk_z80);
        if (exp_adr.size() != 0) begin
            $display("%0d expected writes never appeared before HALT", exp_adr.size());
            flow_errs++;
        end
        print_counts();
        if (data_errs + flow_errs + proto_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Budget scales with the size of the program image
    initial begin
        wait (loaded);
        repeat (m_records * CYCLES_PER_RECORD + HALT_QUIET) @(posedge clk_z80);
        $display("Watchdog expired before the core settled on the halt address");
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- verification/tb_wb_memory.sv
`timescale 1ns/1ps

module tb_wb_memory (
    input  logic             clk_z80,
    input  logic             i_rst,
    input  z80_pkg::wb_req_t i_req,
    output z80_pkg::wb_rsp_t o_rsp,
    output logic             o_acc,
    output logic             o_acc_we,
    output z80_pkg::addr_t   o_acc_adr,
    output z80_pkg::data_t   o_acc_dat,
    output int               o_proto_errs
);
    import z80_pkg::*;

    data_t       mem [0:65535];
    logic [7:0]  lfsr;
    logic [1:0]  delay;
    logic        active;
    int unsigned wait_cnt;
    wb_req_t     held;

    // x^8 + x^6 + x^5 + x^4 + 1, one new bit per step
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ {i[6:0], i[7]};
        end
    endtask

    task automatic load_byte(input addr_t adr, input data_t dat);
        mem[adr] = dat;
    endtask

    initial begin
        lfsr         = 8'd18;
        active       = 1'b0;
        wait_cnt     = 0;
        o_rsp        = '0;
        o_acc        = 1'b0;
        o_acc_we     = 1'b0;
        o_acc_adr    = '0;
        o_acc_dat    = '0;
        o_proto_errs = 0;
    end

    always @(negedge clk_z80) begin
        o_acc <= 1'b0;
        if (i_rst) begin
            o_rsp.ack <= 1'b0;
            active = 1'b0;
        end else if (o_rsp.ack) begin
            // Handshake completed on the rising edge just passed
            o_rsp.ack <= 1'b0;
            active = 1'b0;
        end else begin
            if (i_req.stb && !i_req.cyc) begin
                $display("Protocol violation at %0t ns: stb is high while cyc is low", $time);
                o_proto_errs = o_proto_errs + 1;
            end
            if (active && !i_req.stb) begin
                $display("Protocol violation at %0t ns: stb dropped before ack", $time);
                o_proto_errs = o_proto_errs + 1;
                active = 1'b0;
            end
            if (active && i_req.stb && (i_req.adr != held.adr || i_req.we != held.we
                    || i_req.dat != held.dat)) begin
                $display("Protocol violation at %0t ns: adr, we or dat changed before ack",
                         $time);
                o_proto_errs = o_proto_errs + 1;
            end
            if (i_req.stb) begin
                if (!active) begin
                    active = 1'b1;
                    held   = i_req;
                    lfsr   = lfsr_next(lfsr);
                    delay[1] = lfsr[0];
                    lfsr   = lfsr_next(lfsr);
                    delay[0] = lfsr[0];
                    wait_cnt = delay;
                end
                if (wait_cnt == 0) begin
                    o_rsp.ack <= 1'b1;
                    o_acc     <= 1'b1;
                    o_acc_we  <= i_req.we;
                    o_acc_adr <= i_req.adr;
                    if (i_req.we) begin
                        mem[i_req.adr] = i_req.dat;
                        o_acc_dat <= i_req.dat;
                    end else begin
                        o_rsp.dat <= mem[i_req.adr];
                        o_acc_dat <= mem[i_req.adr];
                    end
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule

//--- source/z80_core.sv
`timescale 1ns/1ps

module z80_core (
    input  logic             clk_z80,
    input  logic             i_rst,
    output z80_pkg::wb_req_t o_wb,
    input  z80_pkg::wb_rsp_t i_wb
);
    import z80_pkg::*;

    bus_cmd_t   cmd;
    reg_wr_t    wr;
    alu_op_t    alu_op;
    logic       busy, done, ex_af, pc_load;
    logic [2:0] rsel;
    logic [1:0] psel;
    data_t      rdata, r8, a, f, alu_a8, alu_r8, alu_f;
    addr_t      pc_next, rp, hl, pc, alu_a16, alu_b16, alu_r16;

    z80_control u_z80_control (
        .clk_z80(clk_z80), .i_rst(i_rst), .o_cmd(cmd), .i_busy(busy), .i_done(done),
        .i_rdata(rdata), .o_wr(wr), .o_ex_af(ex_af), .o_pc_load(pc_load),
        .o_pc_next(pc_next), .o_rsel(rsel), .o_psel(psel), .i_r8(r8), .i_rp(rp),
        .i_a(a), .i_f(f), .i_hl(hl), .i_pc(pc), .o_alu_op(alu_op), .o_alu_a8(alu_a8),
        .o_alu_a16(alu_a16), .o_alu_b16(alu_b16), .i_alu_r8(alu_r8),
        .i_alu_r16(alu_r16), .i_alu_f(alu_f)
    );

    z80_regfile u_z80_regfile (
        .clk_z80(clk_z80), .i_rst(i_rst), .i_wr(wr), .i_ex_af(ex_af),
        .i_pc_next(pc_next), .i_pc_load(pc_load), .i_rsel(rsel), .i_psel(psel),
        .o_r8(r8), .o_rp(rp), .o_a(a), .o_f(f), .o_hl(hl), .o_pc(pc)
    );

    z80_alu u_z80_alu (
        .i_op(alu_op), .i_a8(alu_a8), .i_a16(alu_a16), .i_b16(alu_b16), .i_f(f),
        .o_r8(alu_r8), .o_r16(alu_r16), .o_f(alu_f)
    );

    z80_bus_master u_z80_bus_master (
        .clk_z80(clk_z80), .i_rst(i_rst), .i_cmd(cmd), .o_busy(busy), .o_done(done),
        .o_rdata(rdata), .o_wb(o_wb), .i_wb(i_wb)
    );

endmodule

//--- source/z80_control.sv
`timescale 1ns/1ps

module z80_control (
    input  logic              clk_z80,
    input  logic              i_rst,
    output z80_pkg::bus_cmd_t o_cmd,
    input  logic              i_busy,
    input  logic              i_done,
    input  z80_pkg::data_t    i_rdata,
    output z80_pkg::reg_wr_t  o_wr,
    output logic              o_ex_af,
    output logic              o_pc_load,
    output z80_pkg::addr_t    o_pc_next,
    output logic [2:0]        o_rsel,
    output logic [1:0]        o_psel,
    input  z80_pkg::data_t    i_r8,
    input  z80_pkg::addr_t    i_rp,
    input  z80_pkg::data_t    i_a,
    input  z80_pkg::data_t    i_f,
    input  z80_pkg::addr_t    i_hl,
    input  z80_pkg::addr_t    i_pc,
    output z80_pkg::alu_op_t  o_alu_op,
    output z80_pkg::data_t    o_alu_a8,
    output z80_pkg::addr_t    o_alu_a16,
    output z80_pkg::addr_t    o_alu_b16,
    input  z80_pkg::data_t    i_alu_r8,
    input  z80_pkg::addr_t    i_alu_r16,
    input  z80_pkg::data_t    i_alu_f
);
    import z80_pkg::*;

    typedef enum logic [2:0] {
        FETCH, IMM_LO, IMM_HI, MEM_RD, EXEC, MEM_WR, HALTED
    } state_t;

    state_t state;
    data_t  opcode;
    data_t  op;
    data_t  ld_val;
    addr_t  tmp;
    addr_t  ea;
    addr_t  br_target;
    logic   pend;
    logic   grp0, is_jr, is_ld16, is_add16, is_ind_bd, is_ind_nn;
    logic   is_incdec16, is_incdec8, is_ldn, is_halt, is_ldrr;
    logic   dst_mem, src_mem, ind_load, jr_take;
    logic   need_imm, need_imm16, need_rd, need_wr;

    // While fetching, decode straight from the bus byte
    assign op = (state == FETCH) ? i_rdata : opcode;

    assign grp0        = (op[7:6] == 2'b00);
    assign is_jr       = grp0 && (op[2:0] == 3'b000) && (op[5:4] != 2'b00);
    assign is_ld16     = grp0 && (op[3:0] == OPL_LD16);
    assign is_add16    = grp0 && (op[3:0] == OPL_ADD16);
    assign is_ind_bd   = grp0 && (op[2:0] == OPL_IND) && !op[5];
    assign is_ind_nn   = grp0 && (op[2:0] == OPL_IND) && (op[5:4] == 2'b11);
    assign is_incdec16 = grp0 && (op[2:0] == OPL_INCDEC16);
    assign is_incdec8  = grp0 && (op[2:1] == OPL_INCDEC8);
    assign is_ldn      = grp0 && (op[2:0] == OPL_LDN);
    assign is_halt     = (op == OP_HALT);
    assign is_ldrr     = (op[7:6] == 2'b01) && !is_halt;
    assign dst_mem     = (op[5:3] == R_MEM);
    assign src_mem     = (op[2:0] == R_MEM);
    assign ind_load    = (is_ind_bd || is_ind_nn) && op[3];

    assign need_imm16 = is_ld16 || is_ind_nn;
    assign need_imm   = need_imm16 || is_jr || is_ldn;
    assign need_rd    = ind_load || ((is_incdec8 || is_ldrr) && (is_ldrr ? src_mem : dst_mem));
    assign need_wr    = ((is_ind_bd || is_ind_nn) && !op[3])
                      || ((is_incdec8 || is_ldn || is_ldrr) && dst_mem);

    // Bit 4 picks C or Z and bit 3 gives the wanted level
    assign jr_take   = ((op[4] ? i_f[FLAG_C] : i_f[FLAG_Z]) == op[3]);
    // PC already points past the displacement byte
    assign br_target = i_pc + {{8{tmp[7]}}, tmp[7:0]};
    assign ld_val    = src_mem ? tmp[7:0] : i_r8;

    assign o_rsel    = is_ldrr ? op[2:0] : ((op == OP_DJNZ) ? R_B : op[5:3]);
    assign o_psel    = op[5:4];
    assign o_alu_a8  = (is_incdec8 && dst_mem) ? tmp[7:0] : i_r8;
    assign o_alu_a16 = is_add16 ? i_hl : i_rp;
    assign o_alu_b16 = i_rp;

    always_comb begin
        if (is_add16) begin
            o_alu_op = ALU_ADD16;
        end else if (is_incdec16) begin
            o_alu_op = op[3] ? ALU_DEC16 : ALU_INC16;
        end else if (is_incdec8 && !op[0]) begin
            o_alu_op = ALU_INC8;
        end else begin
            o_alu_op = ALU_DEC8;
        end
    end

    // One bus request at a time
    always_comb begin
        o_cmd.valid = (state != EXEC) && !pend;
        o_cmd.we    = (state == MEM_WR);
        o_cmd.adr   = (state == MEM_RD || state == MEM_WR) ? ea : i_pc;
        o_cmd.dat   = tmp[7:0];
    end

    always_comb begin
        o_wr       = '0;
        o_wr.sel8  = op[5:3];
        o_wr.sel16 = is_add16 ? RP_HL : op[5:4];
        o_wr.dat8  = i_alu_r8;
        o_wr.dat16 = tmp;
        o_wr.flags = i_alu_f;
        o_ex_af    = 1'b0;
        o_pc_load  = i_done && (state == FETCH || state == IMM_LO || state == IMM_HI);
        o_pc_next  = (state == EXEC && is_jr) ? br_target : i_pc + 16'd1;
        if (state == EXEC) begin
            o_ex_af = (op == OP_EX_AF);
            if (is_ld16) begin
                o_wr.en16 = 1'b1;
            end
            if (is_add16 || is_incdec16) begin
                o_wr.en16  = 1'b1;
                o_wr.dat16 = i_alu_r16;
                o_wr.en_f  = is_add16;
            end
            if (is_incdec8) begin
                o_wr.en8  = !dst_mem;
                o_wr.en_f = 1'b1;
            end
            if (is_ldn || is_ldrr) begin
                o_wr.en8  = !dst_mem;
                o_wr.dat8 = is_ldn ? tmp[7:0] : ld_val;
            end
            if (ind_load) begin
                o_wr.en8  = 1'b1;
                o_wr.sel8 = R_A;
                o_wr.dat8 = tmp[7:0];
            end
            if (op == OP_DJNZ) begin
                o_wr.en8  = 1'b1;
                o_wr.sel8 = R_B;
                o_pc_load = (i_alu_r8 != 8'h00);
            end
            if (op == OP_JR || (is_jr && op[5] && jr_take)) begin
                o_pc_load = 1'b1;
            end
            // Step back so the fetch keeps landing on the HALT byte
            if (is_halt) begin
                o_pc_load = 1'b1;
                o_pc_next = i_pc - 16'd1;
            end
        end
    end

    always_ff @(posedge clk_z80) begin
        if (i_rst) begin
            state  <= FETCH;
            pend   <= 1'b0;
            opcode <= '0;
        end else begin
            if (o_cmd.valid) begin
                pend <= 1'b1;
            end else if (i_done) begin
                pend <= 1'b0;
            end
            case (state)
                FETCH: if (i_done) begin
                    opcode <= i_rdata;
                    if (need_imm) begin
                        state <= IMM_LO;
                    end else begin
                        state <= need_rd ? MEM_RD : EXEC;
                    end
                end
                IMM_LO: if (i_done) state <= need_imm16 ? IMM_HI : EXEC;
                IMM_HI: if (i_done) state <= need_rd ? MEM_RD : EXEC;
                MEM_RD: if (i_done) state <= EXEC;
                EXEC: begin
                    if (is_halt) begin
                        state <= HALTED;
                    end else begin
                        state <= need_wr ? MEM_WR : FETCH;
                    end
                end
                MEM_WR: if (i_done) state <= FETCH;
                default: state <= HALTED;
            endcase
        end
    end

    // Immediates, operand bytes and the effective address
    always_ff @(posedge clk_z80) begin
        if (i_done) begin
            case (state)
                FETCH:  ea <= is_ind_bd ? i_rp : i_hl;
                IMM_LO: tmp[7:0] <= i_rdata;
                IMM_HI: begin
                    tmp[15:8] <= i_rdata;
                    ea        <= {i_rdata, tmp[7:0]};
                end
                MEM_RD: tmp[7:0] <= i_rdata;
                default: ;
            endcase
        end
        if (state == EXEC) begin
            if (is_incdec8) begin
                tmp[7:0] <= i_alu_r8;
            end else if (is_ldrr) begin
                tmp[7:0] <= ld_val;
            end else if (!is_ldn) begin
                tmp[7:0] <= i_a;
            end
        end
    end

    a_no_cmd_when_busy: assert property (@(posedge clk_z80) disable iff (i_rst)
        i_busy |-> !o_cmd.valid);

endmodule

//--- source/z80_bus_master.sv
`timescale 1ns/1ps

module z80_bus_master (
    input  logic              clk_z80,
    input  logic              i_rst,
    input  z80_pkg::bus_cmd_t i_cmd,
    output logic              o_busy,
    output logic              o_done,
    output z80_pkg::data_t    o_rdata,
    output z80_pkg::wb_req_t  o_wb,
    input  z80_pkg::wb_rsp_t  i_wb
);
    import z80_pkg::*;

    wb_req_t req;
    logic    done;
    data_t   rdata;

    always_ff @(posedge clk_z80) begin
        if (i_rst) begin
            req.cyc <= 1'b0;
            req.stb <= 1'b0;
            req.we  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!req.cyc) begin
                if (i_cmd.valid) begin
                    req.cyc <= 1'b1;
                    req.stb <= 1'b1;
                    req.we  <= i_cmd.we;
                end
            end else if (i_wb.ack) begin
                req.cyc <= 1'b0;
                req.stb <= 1'b0;
                req.we  <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    // Address and write data held for the whole cycle
    always_ff @(posedge clk_z80) begin
        if (!req.cyc && i_cmd.valid) begin
            req.adr <= i_cmd.adr;
            req.dat <= i_cmd.dat;
        end
        if (req.stb && i_wb.ack) begin
            rdata <= i_wb.dat;
        end
    end

    assign o_wb    = req;
    assign o_busy  = req.cyc;
    assign o_done  = done;
    assign o_rdata = rdata;

    a_stb_in_cyc: assert property (@(posedge clk_z80) disable iff (i_rst)
        o_wb.stb |-> o_wb.cyc);

    a_hold_until_ack: assert property (@(posedge clk_z80) disable iff (i_rst)
        (o_wb.stb && !i_wb.ack) |=>
            ($stable(o_wb.adr) && $stable(o_wb.we) && $stable(o_wb.dat)));

endmodule

//--- source/z80_alu.sv
`timescale 1ns/1ps

module z80_alu (
    input  z80_pkg::alu_op_t i_op,
    input  z80_pkg::data_t   i_a8,
    input  z80_pkg::addr_t   i_a16,
    input  z80_pkg::addr_t   i_b16,
    input  z80_pkg::data_t   i_f,
    output z80_pkg::data_t   o_r8,
    output z80_pkg::addr_t   o_r16,
    output z80_pkg::data_t   o_f
);
    import z80_pkg::*;

    logic        dec8;
    logic [16:0] sum;
    logic [12:0] half;

    assign dec8 = (i_op == ALU_DEC8);
    assign o_r8 = dec8 ? i_a8 - 8'd1 : i_a8 + 8'd1;

    // Full sum for C, low 12 bits alone for the half carry
    assign sum  = {1'b0, i_a16} + {1'b0, i_b16};
    assign half = {1'b0, i_a16[11:0]} + {1'b0, i_b16[11:0]};

    always_comb begin
        o_f   = i_f;
        o_r16 = sum[15:0];
        case (i_op)
            ALU_INC8, ALU_DEC8: begin
                o_f[FLAG_S]  = o_r8[7];
                o_f[FLAG_Z]  = (o_r8 == 8'h00);
                o_f[FLAG_Y]  = o_r8[3];
                o_f[FLAG_X]  = o_r8[5];
                // Nibble wrapped past 0 or F
                o_f[FLAG_H]  = (o_r8[3:0] == (dec8 ? 4'hF : 4'h0));
                o_f[FLAG_N]  = dec8;
                o_f[FLAG_PV] = 1'b0;
            end
            ALU_ADD16: begin
                o_f[FLAG_C] = sum[16];
                o_f[FLAG_H] = half[12];
                o_f[FLAG_Y] = sum[11];
                o_f[FLAG_X] = sum[13];
                o_f[FLAG_N] = 1'b0;
            end
            ALU_INC16: begin
                o_r16 = i_a16 + 16'd1;
            end
            ALU_DEC16: begin
                o_r16 = i_a16 - 16'd1;
            end
            default: ;
        endcase
    end

endmodule

//--- source/z80_regfile.sv
`timescale 1ns/1ps

module z80_regfile (
    input  logic             clk_z80,
    input  logic             i_rst,
    input  z80_pkg::reg_wr_t i_wr,
    input  logic             i_ex_af,
    input  z80_pkg::addr_t   i_pc_next,
    input  logic             i_pc_load,
    input  logic [2:0]       i_rsel,
    input  logic [1:0]       i_psel,
    output z80_pkg::data_t   o_r8,
    output z80_pkg::addr_t   o_rp,
    output z80_pkg::data_t   o_a,
    output z80_pkg::data_t   o_f,
    output z80_pkg::addr_t   o_hl,
    output z80_pkg::addr_t   o_pc
);
    import z80_pkg::*;

    data_t b, c, d, e, h, l, a, f;
    data_t a_alt, f_alt;
    addr_t sp;
    addr_t pc;

    always_ff @(posedge clk_z80) begin
        if (i_rst) begin
            {b, c, d, e, h, l, a, f} <= '0;
            a_alt <= '0;
            f_alt <= '0;
            sp    <= SP_RESET;
            pc    <= '0;
        end else begin
            if (i_pc_load) begin
                pc <= i_pc_next;
            end
            // EX AF,AF' never shares a cycle with other writes
            if (i_ex_af) begin
                a     <= a_alt;
                f     <= f_alt;
                a_alt <= a;
                f_alt <= f;
            end
            if (i_wr.en_f) begin
                f <= i_wr.flags;
            end
            if (i_wr.en8) begin
                case (i_wr.sel8)
                    R_B:     b <= i_wr.dat8;
                    R_C:     c <= i_wr.dat8;
                    R_D:     d <= i_wr.dat8;
                    R_E:     e <= i_wr.dat8;
                    R_H:     h <= i_wr.dat8;
                    R_L:     l <= i_wr.dat8;
                    R_A:     a <= i_wr.dat8;
                    default: ;
                endcase
            end
            if (i_wr.en16) begin
                case (i_wr.sel16)
                    RP_BC: {b, c} <= i_wr.dat16;
                    RP_DE: {d, e} <= i_wr.dat16;
                    RP_HL: {h, l} <= i_wr.dat16;
                    RP_SP: sp     <= i_wr.dat16;
                endcase
            end
        end
    end

    always_comb begin
        case (i_rsel)
            R_B:     o_r8 = b;
            R_C:     o_r8 = c;
            R_D:     o_r8 = d;
            R_E:     o_r8 = e;
            R_H:     o_r8 = h;
            R_L:     o_r8 = l;
            R_A:     o_r8 = a;
            default: o_r8 = '0;
        endcase
        case (i_psel)
            RP_BC: o_rp = {b, c};
            RP_DE: o_rp = {d, e};
            RP_HL: o_rp = {h, l};
            RP_SP: o_rp = sp;
        endcase
    end

    assign o_a  = a;
    assign o_f  = f;
    assign o_hl = {h, l};
    assign o_pc = pc;

    // A single write bundle targets either one byte or one pair
    a_one_width: assert property (@(posedge clk_z80) disable iff (i_rst)
        !(i_wr.en8 && i_wr.en16));

endmodule

//--- source/z80_pkg.sv
package z80_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        addr_t adr;
        data_t dat;
        logic  we;
        logic  cyc;
        logic  stb;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        data_t dat;
        logic  ack;
    } wb_rsp_t;

    // One access request from the sequencer
    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t adr;
        data_t dat;
    } bus_cmd_t;

    // Register file write bundle
    typedef struct packed {
        logic       en8;
        logic       en16;
        logic       en_f;
        logic [2:0] sel8;
        logic [1:0] sel16;
        data_t      dat8;
        addr_t      dat16;
        data_t      flags;
    } reg_wr_t;

    typedef enum logic [2:0] {
        ALU_INC8,
        ALU_DEC8,
        ALU_ADD16,
        ALU_INC16,
        ALU_DEC16
    } alu_op_t;

    // 8-bit operand codes, as in opcode bits 5:3 and 2:0
    localparam logic [2:0] R_B   = 3'd0;
    localparam logic [2:0] R_C   = 3'd1;
    localparam logic [2:0] R_D   = 3'd2;
    localparam logic [2:0] R_E   = 3'd3;
    localparam logic [2:0] R_H   = 3'd4;
    localparam logic [2:0] R_L   = 3'd5;
    localparam logic [2:0] R_MEM = 3'd6;
    localparam logic [2:0] R_A   = 3'd7;

    // Register pairs, as in opcode bits 5:4
    localparam logic [1:0] RP_BC = 2'd0;
    localparam logic [1:0] RP_DE = 2'd1;
    localparam logic [1:0] RP_HL = 2'd2;
    localparam logic [1:0] RP_SP = 2'd3;

    // Flag bits of F, layout SZ5H3PNC
    localparam int FLAG_C  = 0;
    localparam int FLAG_N  = 1;
    localparam int FLAG_PV = 2;
    localparam int FLAG_Y  = 3;
    localparam int FLAG_H  = 4;
    localparam int FLAG_X  = 5;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_S  = 7;

    // Single opcodes
    localparam data_t OP_EX_AF = 8'h08;
    localparam data_t OP_DJNZ  = 8'h10;
    localparam data_t OP_JR    = 8'h18;
    localparam data_t OP_HALT  = 8'h76;

    // Low opcode fields inside the 00xxxxxx group
    localparam logic [3:0] OPL_LD16     = 4'b0001;
    localparam logic [3:0] OPL_ADD16    = 4'b1001;
    localparam logic [2:0] OPL_IND      = 3'b010;
    localparam logic [2:0] OPL_INCDEC16 = 3'b011;
    localparam logic [1:0] OPL_INCDEC8  = 2'b10;
    localparam logic [2:0] OPL_LDN      = 3'b110;

    localparam addr_t SP_RESET = 16'hDFF0;

endpackage
